// File: src/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

	localparam int addr_w = 32;
	localparam int reg_w = 5;

	// 256 words covers byte addresses 0 to 1023
	localparam int mem_words = 256;
	localparam int fifo_depth = 4;

	// load and store width codes as they appear in funct3
	localparam logic [2:0] f3_b = 3'b000;
	localparam logic [2:0] f3_h = 3'b001;
	localparam logic [2:0] f3_w = 3'b010;
	localparam logic [2:0] f3_bu = 3'b100;
	localparam logic [2:0] f3_hu = 3'b101;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	typedef struct packed {
		logic [addr_w-1:0] pc;
		// address for loads and stores, plain result otherwise
		logic [addr_w-1:0] alu_val;
		logic [addr_w-1:0] store_data;
		logic [2:0]        funct3;
		logic              is_load;
		logic              is_store;
		logic              is_jal;
		logic [reg_w-1:0]  rd;
	} mem_req_t;

	typedef struct packed {
		logic [addr_w-1:0] pc;
		logic [reg_w-1:0]  rd;
		logic [addr_w-1:0] value;
		logic              fault;
	} wb_res_t;

endpackage

`default_nettype wire

// File: src/stage_fifo.sv
`default_nettype none

module stage_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 4
) (
	input  wire           clock,
	input  wire           arst_n,

	input  wire           in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,

	output logic          out_valid,
	input  wire           out_ready,
	output payload_t      out_data
);

	payload_t mem [depth];

	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic [$clog2(depth+1)-1:0] count;

	logic push;
	logic pop;

	assign in_ready = (count != depth);
	assign out_valid = (count != 0);
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// the pointers meet only when the buffer is empty or full
	a_ptr_meet: assert property (@(posedge clock) disable iff (!arst_n)
		(wr_ptr == rd_ptr) == (count == 0 || count == depth));

	// the head item must not change under a stalled consumer
	a_out_stable: assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: src/lsu.sv
`default_nettype none

module lsu (
	input  wire                                clock,
	input  wire                                arst_n,

	input  wire                                req_valid,
	output logic                               req_ready,
	input  wire mem_stage_pkg::mem_req_t       req_data,

	output logic                               res_valid,
	input  wire                                res_ready,
	output mem_stage_pkg::wb_res_t             res_data,

	output logic [mem_stage_pkg::addr_w-1:0]   araddr,
	output logic                               arvalid,
	input  wire                                arready,
	input  wire [mem_stage_pkg::addr_w-1:0]    rdata,
	input  wire [1:0]                          rresp,
	input  wire                                rvalid,
	output logic                               rready,

	output logic [mem_stage_pkg::addr_w-1:0]   awaddr,
	output logic                               awvalid,
	input  wire                                awready,
	output logic [mem_stage_pkg::addr_w-1:0]   wdata,
	output logic [mem_stage_pkg::addr_w/8-1:0] wstrb,
	output logic                               wvalid,
	input  wire                                wready,
	input  wire [1:0]                          bresp,
	input  wire                                bvalid,
	output logic                               bready
);

	import mem_stage_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write,
		st_done
	} state_t;

	state_t   state;
	mem_req_t req_q;

	logic [addr_w-1:0]   res_value;
	logic                res_fault;
	logic [addr_w/8-1:0] strb_base;
	logic [addr_w-1:0]   load_shift;
	logic [addr_w-1:0]   load_val;
	logic                accept;

	// idle also means the last result has already been handed on
	assign req_ready = (state == st_idle);
	assign accept = req_valid && req_ready;

	assign res_valid = (state == st_done);
	assign res_data = '{pc: req_q.pc, rd: req_q.rd, value: res_value, fault: res_fault};

	assign rready = (state == st_read);
	assign bready = (state == st_write);

	assign araddr = req_q.alu_val;
	assign awaddr = req_q.alu_val;

	always_comb begin
		case (req_q.funct3[1:0])
			2'b00: strb_base = 4'h1;
			2'b01: strb_base = 4'h3;
			default: strb_base = 4'hf;
		endcase
	end

	// move the store bytes onto the lanes picked by the low address bits
	assign wstrb = strb_base << req_q.alu_val[1:0];
	assign wdata = req_q.store_data << {req_q.alu_val[1:0], 3'b000};

	always_comb begin
		load_shift = rdata >> {req_q.alu_val[1:0], 3'b000};
		case (req_q.funct3)
			f3_b: load_val = {{(addr_w-8){load_shift[7]}}, load_shift[7:0]};
			f3_h: load_val = {{(addr_w-16){load_shift[15]}}, load_shift[15:0]};
			f3_w: load_val = load_shift;
			f3_bu: load_val = {{(addr_w-8){1'b0}}, load_shift[7:0]};
			f3_hu: load_val = {{(addr_w-16){1'b0}}, load_shift[15:0]};
			default: load_val = load_shift;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						if (req_data.is_load) begin
							state <= st_read;
							arvalid <= 1'b1;
						end else if (req_data.is_store) begin
							state <= st_write;
							awvalid <= 1'b1;
							wvalid <= 1'b1;
						end else begin
							state <= st_done;
						end
					end
				end
				st_read: begin
					if (arvalid && arready) begin
						arvalid <= 1'b0;
					end
					if (rvalid && rready) begin
						state <= st_done;
					end
				end
				st_write: begin
					// address and data may be taken on different cycles
					if (awvalid && awready) begin
						awvalid <= 1'b0;
					end
					if (wvalid && wready) begin
						wvalid <= 1'b0;
					end
					if (bvalid && bready) begin
						state <= st_done;
					end
				end
				st_done: begin
					if (res_ready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= req_data;
			res_value <= req_data.is_jal ? req_data.pc + addr_w'(4) : req_data.alu_val;
			res_fault <= 1'b0;
		end else if (rvalid && rready) begin
			res_value <= load_val;
			res_fault <= (rresp != resp_okay);
		end else if (bvalid && bready) begin
			res_fault <= (bresp != resp_okay);
		end
	end

	// upstream must not hand over misaligned accesses, there is no trap for them
	a_half_aligned: assert property (@(posedge clock) disable iff (!arst_n)
		accept && (req_data.is_load || req_data.is_store) &&
		req_data.funct3[1:0] == f3_h[1:0] |-> req_data.alu_val[0] == 1'b0);

	a_word_aligned: assert property (@(posedge clock) disable iff (!arst_n)
		accept && (req_data.is_load || req_data.is_store) &&
		req_data.funct3[1:0] == f3_w[1:0] |-> req_data.alu_val[1:0] == 2'b00);

	a_one_kind: assert property (@(posedge clock) disable iff (!arst_n)
		req_valid |-> !(req_data.is_load && req_data.is_store));

endmodule

`default_nettype wire

// File: src/axi_lite_sram.sv
`default_nettype none

module axi_lite_sram (
	input  wire                                clock,
	input  wire                                arst_n,

	input  wire [mem_stage_pkg::addr_w-1:0]    araddr,
	input  wire                                arvalid,
	output logic                               arready,
	output logic [mem_stage_pkg::addr_w-1:0]   rdata,
	output logic [1:0]                         rresp,
	output logic                               rvalid,
	input  wire                                rready,

	input  wire [mem_stage_pkg::addr_w-1:0]    awaddr,
	input  wire                                awvalid,
	output logic                               awready,
	input  wire [mem_stage_pkg::addr_w-1:0]    wdata,
	input  wire [mem_stage_pkg::addr_w/8-1:0]  wstrb,
	input  wire                                wvalid,
	output logic                               wready,
	output logic [1:0]                         bresp,
	output logic                               bvalid,
	input  wire                                bready
);

	import mem_stage_pkg::*;

	logic [addr_w-1:0] mem [mem_words];

	logic ar_hit;
	logic aw_hit;
	logic rd_in_range;
	logic wr_in_range;

	// anything at or above mem_words words answers with an error
	assign rd_in_range = (araddr[addr_w-1:2] < mem_words);
	assign wr_in_range = (awaddr[addr_w-1:2] < mem_words);

	assign arready = !rvalid;
	assign ar_hit = arvalid && arready;

	// address and data are taken together in one cycle
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign aw_hit = awvalid && awready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (ar_hit) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end

			if (aw_hit) begin
				bvalid <= 1'b1;
				if (wr_in_range) begin
					for (int b = 0; b < addr_w / 8; b++) begin
						if (wstrb[b]) begin
							mem[awaddr[2 +: $clog2(mem_words)]][8*b +: 8] <= wdata[8*b +: 8];
						end
					end
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hit) begin
			rdata <= rd_in_range ? mem[araddr[2 +: $clog2(mem_words)]] : '0;
			rresp <= rd_in_range ? resp_okay : resp_slverr;
		end
		if (aw_hit) begin
			bresp <= wr_in_range ? resp_okay : resp_slverr;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`default_nettype none

module mem_stage (
	input  wire                               clock,
	input  wire                               arst_n,

	input  wire                               req_valid,
	output logic                              req_ready,
	input  wire [mem_stage_pkg::addr_w-1:0]   req_pc,
	input  wire [mem_stage_pkg::addr_w-1:0]   req_alu,
	input  wire [mem_stage_pkg::addr_w-1:0]   req_store_data,
	input  wire [2:0]                         req_funct3,
	input  wire                               req_load,
	input  wire                               req_store,
	input  wire                               req_jal,
	input  wire [mem_stage_pkg::reg_w-1:0]    req_rd,

	output logic                              wb_valid,
	input  wire                               wb_ready,
	output logic [mem_stage_pkg::addr_w-1:0]  wb_pc,
	output logic [mem_stage_pkg::reg_w-1:0]   wb_rd,
	output logic [mem_stage_pkg::addr_w-1:0]  wb_value,
	output logic                              wb_fault
);

	import mem_stage_pkg::*;

	wire mem_req_t req_in;
	wire mem_req_t lsu_req_data;
	wire           lsu_req_valid;
	wire           lsu_req_ready;

	wire wb_res_t  lsu_res_data;
	wire           lsu_res_valid;
	wire           lsu_res_ready;
	wire wb_res_t  wb_out;

	wire [addr_w-1:0]   araddr;
	wire                arvalid;
	wire                arready;
	wire [addr_w-1:0]   rdata;
	wire [1:0]          rresp;
	wire                rvalid;
	wire                rready;
	wire [addr_w-1:0]   awaddr;
	wire                awvalid;
	wire                awready;
	wire [addr_w-1:0]   wdata;
	wire [addr_w/8-1:0] wstrb;
	wire                wvalid;
	wire                wready;
	wire [1:0]          bresp;
	wire                bvalid;
	wire                bready;

	assign req_in = '{pc: req_pc, alu_val: req_alu, store_data: req_store_data,
		funct3: req_funct3, is_load: req_load, is_store: req_store, is_jal: req_jal,
		rd: req_rd};

	assign wb_pc = wb_out.pc;
	assign wb_rd = wb_out.rd;
	assign wb_value = wb_out.value;
	assign wb_fault = wb_out.fault;

	stage_fifo #(.payload_t(mem_req_t), .depth(fifo_depth)) req_fifo_i (
		.clock(clock), .arst_n(arst_n),
		.in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
		.out_valid(lsu_req_valid), .out_ready(lsu_req_ready), .out_data(lsu_req_data)
	);

	lsu lsu_i (
		.clock(clock), .arst_n(arst_n),
		.req_valid(lsu_req_valid), .req_ready(lsu_req_ready), .req_data(lsu_req_data),
		.res_valid(lsu_res_valid), .res_ready(lsu_res_ready), .res_data(lsu_res_data),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	axi_lite_sram sram_i (
		.clock(clock), .arst_n(arst_n),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	stage_fifo #(.payload_t(wb_res_t), .depth(fifo_depth)) wb_fifo_i (
		.clock(clock), .arst_n(arst_n),
		.in_valid(lsu_res_valid), .in_ready(lsu_res_ready), .in_data(lsu_res_data),
		.out_valid(wb_valid), .out_ready(wb_ready), .out_data(wb_out)
	);

endmodule

`default_nettype wire

// File: tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1, "value mismatch on %s", name);
	end
endtask

function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] f3);
	int a;
	logic [31:0] w;
	a = int'(addr);
	w = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
	case (f3)
		f3_b: return {{24{w[7]}}, w[7:0]};
		f3_bu: return {24'h0, w[7:0]};
		f3_h: return {{16{w[15]}}, w[15:0]};
		f3_hu: return {16'h0, w[15:0]};
		default: return w;
	endcase
endfunction

task automatic ref_store(input logic [31:0] addr, input logic [31:0] data,
		input logic [2:0] f3);
	int n;
	n = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
	for (int i = 0; i < n; i++) begin
		ref_mem[int'(addr) + i] = data[8*i +: 8];
	end
endtask

// a random in-range address aligned to the access width
function automatic logic [31:0] pick_addr(input logic [2:0] f3);
	logic [31:0] base;
	base = $urandom_range(mem_words - 1, 0) * 4;
	case (f3[1:0])
		2'b00: return base + $urandom_range(3, 0);
		2'b01: return base + 2 * $urandom_range(1, 0);
		default: return base;
	endcase
endfunction

// called at a rising edge, returns at the edge where the request was taken
task automatic issue_req(input logic [31:0] pc, input logic [31:0] alu,
		input logic [31:0] sdata, input logic [2:0] f3, input logic ld,
		input logic st, input logic jal, input logic [4:0] rd);
	expect_t e;
	e.res.pc = pc;
	e.res.rd = rd;
	e.res.fault = (ld || st) && (alu >= mem_words * 4);
	e.has_value = !st;
	if (ld) begin
		e.res.value = e.res.fault ? 32'h0 : ref_load(alu, f3);
	end else if (jal) begin
		e.res.value = pc + 32'd4;
	end else begin
		e.res.value = alu;
	end
	if (st && !e.res.fault) begin
		ref_store(alu, sdata, f3);
	end
	exp_q.push_back(e);
	req_valid <= 1'b1;
	req_pc <= pc;
	req_alu <= alu;
	req_store_data <= sdata;
	req_funct3 <= f3;
	req_load <= ld;
	req_store <= st;
	req_jal <= jal;
	req_rd <= rd;
	do @(posedge clock); while (!req_ready);
endtask

task automatic drop_req();
	req_valid <= 1'b0;
endtask

task automatic wait_drain();
	drop_req();
	while (exp_q.size() != 0) @(posedge clock);
endtask

task automatic alu_passthrough();
	for (int i = 0; i < 8; i++) begin
		issue_req($urandom & 32'hffff_fffc, $urandom, 32'h0, f3_w, 1'b0, 1'b0, i[0], 5'(i + 1));
	end
	wait_drain();
endtask

task automatic word_store_load();
	logic [31:0] addrs [8];
	for (int i = 0; i < 8; i++) begin
		addrs[i] = pick_addr(f3_w);
		issue_req(32'h100 + 4 * i, addrs[i], $urandom, f3_w, 1'b0, 1'b1, 1'b0, 5'd0);
	end
	for (int i = 0; i < 8; i++) begin
		issue_req(32'h200 + 4 * i, addrs[i], 32'h0, f3_w, 1'b1, 1'b0, 1'b0, 5'(i + 8));
	end
	wait_drain();
endtask

task automatic subword_lanes();
	logic [31:0] base;
	base = pick_addr(f3_w);
	for (int off = 0; off < 4; off++) begin
		issue_req(32'h300, base + off, $urandom, f3_b, 1'b0, 1'b1, 1'b0, 5'd0);
		issue_req(32'h304, base, 32'h0, f3_w, 1'b1, 1'b0, 1'b0, 5'd3);
		issue_req(32'h308, base + off, 32'h0, f3_b, 1'b1, 1'b0, 1'b0, 5'd4);
		issue_req(32'h30c, base + off, 32'h0, f3_bu, 1'b1, 1'b0, 1'b0, 5'd5);
	end
	for (int off = 0; off < 4; off += 2) begin
		issue_req(32'h400, base + off, $urandom, f3_h, 1'b0, 1'b1, 1'b0, 5'd0);
		issue_req(32'h404, base, 32'h0, f3_w, 1'b1, 1'b0, 1'b0, 5'd6);
		issue_req(32'h408, base + off, 32'h0, f3_h, 1'b1, 1'b0, 1'b0, 5'd7);
		issue_req(32'h40c, base + off, 32'h0, f3_hu, 1'b1, 1'b0, 1'b0, 5'd9);
	end
	wait_drain();
endtask

task automatic out_of_range_faults();
	logic [31:0] word;
	word = pick_addr(f3_w);
	// the upper address bits alias onto an in-range word if the range check were missing
	issue_req(32'h500, word + 32'h400, $urandom, f3_w, 1'b0, 1'b1, 1'b0, 5'd0);
	issue_req(32'h504, word + 32'h400, 32'h0, f3_w, 1'b1, 1'b0, 1'b0, 5'd10);
	issue_req(32'h508, 32'hffff_fff1, 32'h0, f3_b, 1'b1, 1'b0, 1'b0, 5'd11);
	issue_req(32'h50c, word, 32'h0, f3_w, 1'b1, 1'b0, 1'b0, 5'd12);
	wait_drain();
endtask

task automatic backpressure_burst();
	logic [2:0] f3_list [5];
	logic [2:0] f3;
	int         kind;
	f3_list = '{f3_b, f3_h, f3_w, f3_bu, f3_hu};
	stalling = 1'b1;
	fork
		begin
			for (int i = 0; i < 20; i++) begin
				kind = $urandom_range(3, 0);
				if (kind == 2) begin
					f3 = f3_list[$urandom_range(2, 0)];
					issue_req(32'h600 + 4 * i, pick_addr(f3), $urandom, f3, 1'b0, 1'b1,
						1'b0, 5'd0);
				end else if (kind == 3) begin
					f3 = f3_list[$urandom_range(4, 0)];
					issue_req(32'h600 + 4 * i, pick_addr(f3), 32'h0, f3, 1'b1, 1'b0,
						1'b0, 5'(i + 1));
				end else begin
					issue_req(32'h600 + 4 * i, $urandom, 32'h0, f3_w, 1'b0, 1'b0,
						kind == 1, 5'(i + 1));
				end
			end
			wait_drain();
			stalling = 1'b0;
		end
		begin
			while (stalling) begin
				@(posedge clock);
				wb_ready <= 1'($urandom_range(1, 0));
			end
			wb_ready <= 1'b1;
		end
	join
endtask

`endif

// File: tb/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;

	import mem_stage_pkg::*;

	// roughly 72 requests, none of which needs 20 cycles even under random stalls
	localparam int max_cycles = 4000;

	typedef struct {
		wb_res_t res;
		// stores carry no defined result value, so only pc, rd and fault are compared
		bit      has_value;
	} expect_t;

	logic              clock = 1'b0;
	logic              arst_n;

	logic              req_valid;
	logic              req_ready;
	logic [addr_w-1:0] req_pc;
	logic [addr_w-1:0] req_alu;
	logic [addr_w-1:0] req_store_data;
	logic [2:0]        req_funct3;
	logic              req_load;
	logic              req_store;
	logic              req_jal;
	logic [reg_w-1:0]  req_rd;

	logic              wb_valid;
	logic              wb_ready;
	logic [addr_w-1:0] wb_pc;
	logic [reg_w-1:0]  wb_rd;
	logic [addr_w-1:0] wb_value;
	logic              wb_fault;

	// byte image of what the SRAM should hold
	logic [7:0] ref_mem [mem_words*4];

	expect_t exp_q [$];
	expect_t head;
	int      cycles;
	bit      stalling;

	always #50 clock = ~clock;

	mem_stage dut_i (
		.clock(clock),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_pc(req_pc),
		.req_alu(req_alu),
		.req_store_data(req_store_data),
		.req_funct3(req_funct3),
		.req_load(req_load),
		.req_store(req_store),
		.req_jal(req_jal),
		.req_rd(req_rd),
		.wb_valid(wb_valid),
		.wb_ready(wb_ready),
		.wb_pc(wb_pc),
		.wb_rd(wb_rd),
		.wb_value(wb_value),
		.wb_fault(wb_fault)
	);

	`include "tb_tasks.svh"

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TESTS FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// every result leaving the writeback FIFO is matched against the oldest expectation
	always @(posedge clock) begin
		if (arst_n && wb_valid && wb_ready) begin
			if (exp_q.size() == 0) begin
				$display("a result came out while no request was pending");
				$display("TESTS FAILED");
				$fatal(1, "unexpected writeback result");
			end else begin
				head = exp_q.pop_front();
				check_value("wb_pc", wb_pc, head.res.pc);
				check_value("wb_rd", wb_rd, head.res.rd);
				check_value("wb_fault", wb_fault, head.res.fault);
				if (head.has_value) begin
					check_value("wb_value", wb_value, head.res.value);
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h567d15e1));
		cycles = 0;
		stalling = 1'b0;
		arst_n = 1'b0;
		req_valid = 1'b0;
		req_pc = '0;
		req_alu = '0;
		req_store_data = '0;
		req_funct3 = '0;
		req_load = 1'b0;
		req_store = 1'b0;
		req_jal = 1'b0;
		req_rd = '0;
		wb_ready = 1'b1;
		for (int i = 0; i < mem_words * 4; i++) begin
			ref_mem[i] = 8'h00;
		end

		repeat (2) @(posedge clock);
		arst_n <= 1'b1;
		@(posedge clock);

		alu_passthrough();
		word_store_load();
		subword_lanes();
		out_of_range_faults();
		backpressure_burst();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tb
src/mem_stage_pkg.sv
src/stage_fifo.sv
src/lsu.sv
src/axi_lite_sram.sv
src/mem_stage.sv
tb/tb_mem_stage.sv
